//--- logic/mapper_pkg.sv
// Shared types and address map constants for the cartridge mapper block
// Imported by every stage and mapper that handles requests or configuration
`default_nettype none

package mapper_pkg;

    localparam int rom_addr_bits = 21;          // 2 MB ROM space

    // Cartridge page window, slots 1 and 2 of the Z80 map
    localparam logic [15:0] page_lo = 16'h4000;
    localparam logic [15:0] page_hi = 16'hBFFF;

    // Bank register windows, matched on address bits 15:11
    localparam logic [4:0] ascii16_bank0_win = 5'b01100;  // 6000h-67FFh
    localparam logic [4:0] ascii16_bank1_win = 5'b01110;  // 7000h-77FFh
    localparam logic [2:0] ascii8_bank_win   = 3'b011;    // 6000h-7FFFh, bits 15:13
    localparam logic [1:0] scc_bank_sub      = 2'b10;     // x000h-x7FFh inside a page, bits 12:11
    localparam logic [4:0] scc_reg_win       = 5'b10011;  // 9800h-9FFFh
    localparam logic [5:0] scc_enable_value  = 6'h3F;     // Bank 2 value that opens the SCC

    // Which mapper the slot carries
    typedef enum logic [1:0] {
        none       = 2'd0,
        ascii8     = 2'd1,
        ascii16    = 2'd2,
        konami_scc = 2'd3
    } mapper_t;

    // Static block configuration
    typedef struct packed {
        mapper_t mapper;                       // Active mapper
        logic    enable;                       // Slot populated
    } block_info_t;

    // One captured CPU bus cycle
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  data;
        logic        rd;
        logic        wr;
        logic        sel;                      // Slot selected
    } cpu_req_t;

    // Result of one mapper, idle-safe for AND/OR merging
    typedef struct packed {
        logic [rom_addr_bits-1:0] addr;        // All ones when idle
        logic                     rnw;         // High when idle
        logic                     rom_cs;
        logic                     scc_en;      // Sound chip register strobe
    } mapper_out_t;

    // Registered request toward external memory
    typedef struct packed {
        logic [rom_addr_bits-1:0] addr;
        logic                     rnw;
        logic                     rom_cs;
        logic                     scc_en;
    } mem_req_t;

    localparam mapper_out_t mapper_idle = '{
        addr:   {rom_addr_bits{1'b1}},
        rnw:    1'b1,
        rom_cs: 1'b0,
        scc_en: 1'b0
    };

endpackage

`default_nettype wire

//--- logic/cpu_request_stage.sv
// First pipeline stage, registers the raw CPU bus into a request struct
// Strobes are cleared on reset so nothing reaches the bank registers early
`timescale 1ns/1ps
`default_nettype none

module cpu_request_stage
    import mapper_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic [15:0] cpu_addr,
    input  wire logic [7:0]  cpu_data_in,
    input  wire logic        cpu_rd,
    input  wire logic        cpu_wr,
    input  wire logic        slot_sel,
    output cpu_req_t         req
);

    // Control strobes
    always_ff @(posedge clk) begin
        if (reset) begin
            req.rd  <= 1'b0;
            req.wr  <= 1'b0;
            req.sel <= 1'b0;
        end else begin
            req.rd  <= cpu_rd;
            req.wr  <= cpu_wr;
            req.sel <= slot_sel;
        end
    end

    // Address and data just follow the bus
    always_ff @(posedge clk) begin
        req.addr <= cpu_addr;
        req.data <= cpu_data_in;                // Bank value on writes
    end

endmodule

`default_nettype wire

//--- logic/mapper_ascii8.sv
// ASCII8 mapper, four 8 KB banks over 4000h-BFFFh
// Bank registers sit at 6000h, 6800h, 7000h and 7800h
`timescale 1ns/1ps
`default_nettype none

module mapper_ascii8
    import mapper_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  reset,
    input  cpu_req_t   req,
    input  block_info_t block_info,
    output mapper_out_t out
);

    logic [7:0] bank [4];                       // One register per 8 KB page
    logic       active;
    logic       bank_wr;
    logic [1:0] page;

    assign active = block_info.enable && block_info.mapper == ascii8 && req.sel &&
                    req.addr >= page_lo && req.addr <= page_hi;

    // 6000h-7FFFh, register picked by bits 12:11
    assign bank_wr = active && req.wr && req.addr[15:13] == ascii8_bank_win;

    // 4000h->0, 6000h->1, 8000h->2, A000h->3
    assign page = {~req.addr[14], req.addr[13]};

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                bank[i] <= 8'h00;
            end
        end else if (bank_wr) begin
            bank[req.addr[12:11]] <= req.data;
        end
    end

    always_comb begin
        out = mapper_idle;
        if (active && req.rd) begin
            out.addr   = {bank[page], req.addr[12:0]};  // 8 + 13 bits
            out.rnw    = 1'b1;
            out.rom_cs = 1'b1;
        end else if (active && req.wr) begin
            out.rnw = 1'b0;                     // ROM not selected on writes
        end
    end

endmodule

`default_nettype wire

//--- logic/mapper_ascii16.sv
// ASCII16 mapper, two 16 KB banks over 4000h-BFFFh
// Bank 0 written at 6000h-67FFh, bank 1 at 7000h-77FFh
`timescale 1ns/1ps
`default_nettype none

module mapper_ascii16
    import mapper_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  reset,
    input  cpu_req_t   req,
    input  block_info_t block_info,
    output mapper_out_t out
);

    logic [6:0] bank0;                          // 4000h-7FFFh
    logic [6:0] bank1;                          // 8000h-BFFFh
    logic       active;
    logic       wr_hit;

    assign active = block_info.enable && block_info.mapper == ascii16 && req.sel &&
                    req.addr >= page_lo && req.addr <= page_hi;
    assign wr_hit = active && req.wr;

    always_ff @(posedge clk) begin
        if (reset) begin
            bank0 <= 7'h00;
            bank1 <= 7'h00;
        end else begin
            if (wr_hit && req.addr[15:11] == ascii16_bank0_win) bank0 <= req.data[6:0];
            if (wr_hit && req.addr[15:11] == ascii16_bank1_win) bank1 <= req.data[6:0];
        end
    end

    always_comb begin
        out = mapper_idle;
        if (active && req.rd) begin
            // Upper half of the window uses bank 1
            out.addr   = {req.addr[15] ? bank1 : bank0, req.addr[13:0]};
            out.rnw    = 1'b1;
            out.rom_cs = 1'b1;
        end else if (wr_hit) begin
            out.rnw = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- logic/mapper_konami_scc.sv
// Konami SCC mapper, four 8 KB banks plus the sound chip register window
// Banks written at 5000h, 7000h, 9000h and B000h; SCC opens when bank 2 is 3Fh
`timescale 1ns/1ps
`default_nettype none

module mapper_konami_scc
    import mapper_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  reset,
    input  cpu_req_t   req,
    input  block_info_t block_info,
    output mapper_out_t out
);

    logic [7:0] bank [4];
    logic       active;
    logic       bank_wr;
    logic       scc_sel;
    logic [1:0] page;

    assign active = block_info.enable && block_info.mapper == konami_scc && req.sel &&
                    req.addr >= page_lo && req.addr <= page_hi;

    // Same page order as ASCII8, 5000h->0 ... B000h->3
    assign page = {~req.addr[14], req.addr[13]};

    // Lower half of each 4 KB upper quarter of the page
    assign bank_wr = active && req.wr && req.addr[12:11] == scc_bank_sub;

    // Register window only when bank 2 selects the SCC
    assign scc_sel = active && (req.rd || req.wr) &&
                     req.addr[15:11] == scc_reg_win &&
                     bank[2][5:0] == scc_enable_value;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                bank[i] <= 8'(i);               // Power-up banks 0..3
            end
        end else if (bank_wr) begin
            bank[page] <= req.data;
        end
    end

    always_comb begin
        out = mapper_idle;
        if (scc_sel) begin
            out.scc_en = 1'b1;                  // ROM stays deselected
            out.rnw    = ~req.wr;
        end else if (active && req.rd) begin
            out.addr   = {bank[page], req.addr[12:0]};
            out.rnw    = 1'b1;
            out.rom_cs = 1'b1;
        end else if (active && req.wr) begin
            out.rnw = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- logic/mappers.sv
// Mapper bank stage, runs every mapper on the same request
// Idle mappers drive all-ones address and high rnw, so AND/OR merging picks the active one
`timescale 1ns/1ps
`default_nettype none

module mappers
    import mapper_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  reset,
    input  cpu_req_t   req,
    input  block_info_t block_info,
    output mapper_out_t merged
);

    mapper_out_t ascii8_out;
    mapper_out_t ascii16_out;
    mapper_out_t scc_out;

    mapper_ascii8 u_ascii8 (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .block_info (block_info),
        .out        (ascii8_out)
    );

    mapper_ascii16 u_ascii16 (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .block_info (block_info),
        .out        (ascii16_out)
    );

    mapper_konami_scc u_konami_scc (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .block_info (block_info),
        .out        (scc_out)
    );

    // Addresses and read levels by AND, selects by OR
    assign merged.addr   = ascii8_out.addr & ascii16_out.addr & scc_out.addr;
    assign merged.rnw    = ascii8_out.rnw & ascii16_out.rnw & scc_out.rnw;
    assign merged.rom_cs = ascii8_out.rom_cs | ascii16_out.rom_cs | scc_out.rom_cs;
    assign merged.scc_en = scc_out.scc_en;      // Only the SCC mapper has a device

endmodule

`default_nettype wire

//--- logic/memory_request_stage.sv
// Last pipeline stage, registers the merged mapper result toward memory
// Keeps the combinational decode glitches away from the ROM pins
`timescale 1ns/1ps
`default_nettype none

module memory_request_stage
    import mapper_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  reset,
    input  mapper_out_t merged,
    output mem_req_t   mem
);

    always_ff @(posedge clk) begin
        if (reset) begin
            // Idle bus, nothing selected
            mem.addr   <= mapper_idle.addr;
            mem.rnw    <= mapper_idle.rnw;
            mem.rom_cs <= mapper_idle.rom_cs;
            mem.scc_en <= mapper_idle.scc_en;
        end else begin
            mem.addr   <= merged.addr;
            mem.rnw    <= merged.rnw;
            mem.rom_cs <= merged.rom_cs;
            mem.scc_en <= merged.scc_en;        // Device strobe, one cycle
        end
    end

endmodule

`default_nettype wire

//--- logic/cartridge_top.sv
// Cartridge mapper block, CPU request -> mapper banks -> memory request
// Two cycles from CPU bus to the registered ROM request
`timescale 1ns/1ps
`default_nettype none

module cartridge_top
    import mapper_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic [15:0] cpu_addr,
    input  wire logic [7:0]  cpu_data_in,
    input  wire logic        cpu_rd,
    input  wire logic        cpu_wr,
    input  wire logic        slot_sel,
    input  block_info_t      block_info,        // Static slot configuration
    output mem_req_t         mem
);

    cpu_req_t    req;                           // Stage 1 -> 2
    mapper_out_t merged;                        // Stage 2 -> 3

    cpu_request_stage u_cpu_request_stage (
        .clk         (clk),
        .reset       (reset),
        .cpu_addr    (cpu_addr),
        .cpu_data_in (cpu_data_in),
        .cpu_rd      (cpu_rd),
        .cpu_wr      (cpu_wr),
        .slot_sel    (slot_sel),
        .req         (req)
    );

    mappers u_mappers (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .block_info (block_info),
        .merged     (merged)
    );

    memory_request_stage u_memory_request_stage (
        .clk    (clk),
        .reset  (reset),
        .merged (merged),
        .mem    (mem)
    );

endmodule

`default_nettype wire

//--- testbench/cartridge_tb.sv
// Self-checking testbench for the cartridge mapper block
// Runs CPU cycles through all three mappers and checks mem two cycles later
`timescale 1ns/1ps
`default_nettype none

module cartridge_tb
    import mapper_pkg::*;
();

    logic        clk;
    logic        reset;
    logic [15:0] cpu_addr;
    logic [7:0]  cpu_data_in;
    logic        cpu_rd;
    logic        cpu_wr;
    logic        slot_sel;
    block_info_t block_info;
    mem_req_t    mem;

    block_info_t cfg;                           // Model copy of the slot config
    logic [7:0]  a8_bank [4];
    logic [6:0]  a16_bank [2];
    logic [7:0]  scc_bank [4];
    logic [31:0] lcg_state;
    mem_req_t    cur_exp;                       // Cycle driven this clock
    mem_req_t    d1_exp;
    mem_req_t    d2_exp;                        // Due on mem now
    logic        cur_valid;
    logic        d1_valid;
    logic        d2_valid;
    int          checks;
    int          errors;
    int          test_checks;
    int          test_errors;

    cartridge_top uut (
        .clk         (clk),
        .reset       (reset),
        .cpu_addr    (cpu_addr),
        .cpu_data_in (cpu_data_in),
        .cpu_rd      (cpu_rd),
        .cpu_wr      (cpu_wr),
        .slot_sel    (slot_sel),
        .block_info  (block_info),
        .mem         (mem)
    );

    always #5 clk = ~clk;                       // 100 MHz

    function automatic mem_req_t idle_req();
        mem_req_t e;
        e.addr   = '1;
        e.rnw    = 1'b1;
        e.rom_cs = 1'b0;
        e.scc_en = 1'b0;
        return e;
    endfunction

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    function automatic logic [15:0] rand_page_addr();
        logic [15:0] r;
        r = lcg_next();
        return 16'h4000 + {1'b0, r[14:0]};      // 4000h-BFFFh
    endfunction

    task automatic check_mem(input mem_req_t exp);
        checks++;
        assert (mem === exp) else begin
            $display("FAIL t=%0t mem expected %h got %h", $time, exp, mem);
            errors++;
        end
    endtask

    // Reference mapper, result from the current banks, bank writes after
    task automatic model_cycle(input logic [15:0] a, input logic [7:0] d, input logic rd,
                               input logic wr, input logic sel, output mem_req_t e);
        logic        hit;
        logic [1:0]  pg;
        logic [15:0] base;
        e   = idle_req();
        hit = cfg.enable && sel && a >= 16'h4000 && a <= 16'hBFFF;
        pg  = 2'((a - 16'h4000) >> 13);         // 8 KB page inside the window
        if (hit && cfg.mapper == ascii8) begin
            if (rd) begin
                e.addr   = {a8_bank[pg], a[12:0]};
                e.rom_cs = 1'b1;
            end else if (wr) begin
                e.rnw = 1'b0;
                if (a >= 16'h6000 && a <= 16'h7FFF) a8_bank[a[12:11]] = d;
            end
        end else if (hit && cfg.mapper == ascii16) begin
            if (rd) begin
                e.addr   = {(a < 16'h8000) ? a16_bank[0] : a16_bank[1], a[13:0]};
                e.rom_cs = 1'b1;
            end else if (wr) begin
                e.rnw = 1'b0;
                if (a >= 16'h6000 && a <= 16'h67FF) a16_bank[0] = d[6:0];
                if (a >= 16'h7000 && a <= 16'h77FF) a16_bank[1] = d[6:0];
            end
        end else if (hit && cfg.mapper == konami_scc) begin
            if ((rd || wr) && a >= 16'h9800 && a <= 16'h9FFF && scc_bank[2][5:0] == 6'h3F) begin
                e.scc_en = 1'b1;                // SCC window, ROM stays off
                e.rnw    = !wr;
            end else if (rd) begin
                e.addr   = {scc_bank[pg], a[12:0]};
                e.rom_cs = 1'b1;
            end else if (wr) begin
                e.rnw = 1'b0;
                base  = 16'h5000 + 16'(pg) * 16'h2000;  // 5000h, 7000h, 9000h, B000h
                if (a >= base && a <= base + 16'h07FF) scc_bank[pg] = d;
            end
        end
    endtask

    task automatic present_cycle(input logic [15:0] a, input logic [7:0] d, input logic rd,
                                 input logic wr, input logic sel);
        mem_req_t e;
        @(posedge clk);
        cpu_addr    <= a;
        cpu_data_in <= d;
        cpu_rd      <= rd;
        cpu_wr      <= wr;
        slot_sel    <= sel;
        model_cycle(a, d, rd, wr, sel, e);
        cur_exp   = e;
        cur_valid = 1'b1;
    endtask

    task automatic present_read(input logic [15:0] a);
        present_cycle(a, 8'h00, 1'b1, 1'b0, 1'b1);
    endtask

    task automatic present_write(input logic [15:0] a, input logic [7:0] d);
        present_cycle(a, d, 1'b0, 1'b1, 1'b1);
    endtask

    // Bus to idle, then wait for the queued results to be checked
    task automatic drain_pipeline();
        int waited;
        waited = 0;
        @(posedge clk);
        cpu_rd   <= 1'b0;
        cpu_wr   <= 1'b0;
        slot_sel <= 1'b0;
        while ((cur_valid || d1_valid || d2_valid) && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (cur_valid || d1_valid || d2_valid) begin
            $display("Timeout: results still pending after %0d cycles", waited);
            errors++;
        end
    endtask

    task automatic set_config(input mapper_t m, input logic en);
        drain_pipeline();                       // No cycle in flight across a change
        @(posedge clk);
        cfg.mapper = m;
        cfg.enable = en;
        block_info <= cfg;
    endtask

    task automatic end_test(input string name);
        drain_pipeline();
        $display("%-8s %0d checks, %0d errors", name, checks - test_checks, errors - test_errors);
        test_checks = checks;
        test_errors = errors;
    endtask

    // Two-slot delay line, sampled away from the rising edge
    always @(negedge clk) begin
        if (d2_valid) check_mem(d2_exp);
        d2_exp    = d1_exp;
        d2_valid  = d1_valid;
        d1_exp    = cur_exp;
        d1_valid  = cur_valid;
        cur_valid = 1'b0;
    end

    initial begin : main_sequence
        logic [15:0] r;
        clk = 1'b0;
        reset = 1'b1;
        cpu_addr = '0;
        cpu_data_in = '0;
        cpu_rd = 1'b0;
        cpu_wr = 1'b0;
        slot_sel = 1'b0;
        block_info = '0;
        cfg = '0;
        cur_valid = 1'b0;
        d1_valid = 1'b0;
        d2_valid = 1'b0;
        checks = 0;
        errors = 0;
        test_checks = 0;
        test_errors = 0;
        lcg_state = 32'd95;
        for (int i = 0; i < 4; i++) begin
            a8_bank[i]  = 8'h00;
            scc_bank[i] = 8'(i);                // Konami power-up banks 0..3
        end
        a16_bank[0] = 7'h00;
        a16_bank[1] = 7'h00;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        repeat (2) begin
            @(negedge clk);
            check_mem(idle_req());
        end
        end_test("reset");

        set_config(ascii8, 1'b1);
        for (int i = 0; i < 4; i++) begin
            r = lcg_next();
            present_write(16'h6000 + 16'(i) * 16'h0800 + {5'b0, r[10:0]}, r[15:8]);
        end
        repeat (16) present_read(rand_page_addr());
        for (int i = 0; i < 4; i++) begin
            r = lcg_next();
            present_write(16'h6000 + 16'(i) * 16'h0800, r[15:8]);  // Then read same bank
            present_read(16'h4000 + 16'(i) * 16'h2000 + {3'b0, r[12:0]});
        end
        end_test("ascii8");

        set_config(ascii16, 1'b1);
        r = lcg_next();
        present_write(16'h6000 + {5'b0, r[10:0]}, r[15:8]);
        r = lcg_next();
        present_write(16'h7000 + {5'b0, r[10:0]}, r[15:8]);
        for (int i = 0; i < 2; i++) begin
            repeat (4) begin
                r = lcg_next();
                present_read(16'h4000 + {2'b0, r[13:0]});
                present_read(16'h8000 + {2'b0, r[13:0]});
            end
            if (i == 0) begin                   // Outside the register windows
                present_write(16'h6800, r[7:0]);
                present_write(16'h7800, r[15:8]);
                present_write(16'h5000, 8'h55);
                present_write(16'hA000, 8'h2A);
            end
        end
        end_test("ascii16");

        set_config(konami_scc, 1'b1);
        for (int i = 0; i < 4; i++) begin
            r = lcg_next();
            present_read(16'h4000 + 16'(i) * 16'h2000 + {3'b0, r[12:0]});
        end
        present_write(16'h9000, 8'h3F);         // Opens the SCC window
        repeat (4) begin
            r = lcg_next();
            present_read(16'h9800 + {5'b0, r[10:0]});
        end
        present_write(16'h9800, r[15:8]);
        present_read(16'h9000 + {5'b0, r[10:0]});
        r = lcg_next();
        present_write(16'h9000, {r[7:6], 1'b0, r[4:0]});  // Never 3Fh in the low bits
        present_read(16'h9800 + {5'b0, r[10:0]});
        end_test("scc");

        set_config(ascii8, 1'b1);
        r = lcg_next();
        present_read({2'b00, r[13:0]});         // Below the window
        present_read({2'b11, r[13:0]});         // Above the window
        present_cycle(16'h6000, r[7:0], 1'b0, 1'b1, 1'b0);
        present_cycle(rand_page_addr(), 8'h00, 1'b1, 1'b0, 1'b0);
        set_config(ascii8, 1'b0);
        present_write(16'h6800, r[15:8]);
        present_read(rand_page_addr());
        set_config(none, 1'b1);
        present_write(16'h7000, r[15:8]);
        present_read(rand_page_addr());
        end_test("idle");

        set_config(ascii8, 1'b1);
        repeat (24) present_read(rand_page_addr());
        set_config(ascii16, 1'b1);
        repeat (24) present_read(rand_page_addr());
        set_config(konami_scc, 1'b1);
        repeat (24) present_read(rand_page_addr());
        end_test("stream");

        $display("Total: %0d checks, %0d errors", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
logic/mapper_pkg.sv
logic/cpu_request_stage.sv
logic/mapper_ascii8.sv
logic/mapper_ascii16.sv
logic/mapper_konami_scc.sv
logic/mappers.sv
logic/memory_request_stage.sv
logic/cartridge_top.sv
testbench/cartridge_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the cartridge mapper simulation with Verilator
# Exit status is zero only when the log holds the pass line

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module cartridge_tb -Mdir "$OBJ" -o cartridge_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$OBJ/cartridge_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Test OK$" "$LOG"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed, see $LOG"
exit 1
